// File: hdl/plane_pkg.sv
package plane_pkg;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	// RGB332 colour word, red in the top three bits
	typedef logic [7:0] pixel_t;

	// Address into the 4800-word image
	typedef logic [12:0] rom_addr_t;

	//////////////////////////////////////////////////
	// Stored image
	//////////////////////////////////////////////////

	localparam int IMG_W       = 80;
	localparam int IMG_H       = 60;
	localparam int IMG_WORDS   = IMG_W * IMG_H;
	// Each stored pixel covers 2**SCALE_SHIFT screen pixels per axis
	localparam int SCALE_SHIFT = 3;

	//////////////////////////////////////////////////
	// 640x480 raster, in pixel clocks and lines
	//////////////////////////////////////////////////

	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_TOTAL  = 800;

	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_TOTAL  = 525;

	// Image contents, a diagonal XOR pattern of the address
	function automatic pixel_t image_pattern(input rom_addr_t addr);
		return addr[7:0] ^ addr[12:5];
	endfunction

endpackage

// File: hdl/pixel_fifo_if.sv
`timescale 1ns/1ps

interface pixel_fifo_if import plane_pkg::*; ();

	// Write strobe and data from the ROM side
	logic   wr_en;
	pixel_t wr_data;

	// Status back from the FIFO
	// Room means at least two free slots
	logic   room;
	logic   full;
	logic   empty;

	// Fetch path, ROM drives the write and the address generator watches room
	modport writer (
		output wr_en,
		output wr_data,
		input  room,
		input  full,
		input  empty
	);

	modport fifo (
		input  wr_en,
		input  wr_data,
		output room,
		output full,
		output empty
	);

endinterface

// File: hdl/display_plane.sv
`timescale 1ns/1ps

module display_plane import plane_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	pixel_fifo_if.writer        fifo,
	output logic                fetch,
	output rom_addr_t           rom_addr
);

	// Two-state walker, a fetch only ever leaves from FILL
	localparam logic READ = 1'b0;
	localparam logic FILL = 1'b1;

	localparam logic [6:0] LAST_COL  = 7'(IMG_W - 1);
	localparam rom_addr_t  LAST_BASE = rom_addr_t'((IMG_H - 1) * IMG_W);

	logic                   state;
	logic                   next_state;

	// Repeat counters for the 8x scale
	logic [SCALE_SHIFT-1:0] h_rep;
	logic [SCALE_SHIFT-1:0] v_rep;
	// Stored column and start address of the stored line
	logic [6:0]             col;
	rom_addr_t              line_base;

	logic                   last_rep_h;
	logic                   last_col;
	logic                   end_of_line;

	//////////////////////////////////////////////////
	// Address and strobe
	//////////////////////////////////////////////////

	assign fetch    = (state == FILL);
	assign rom_addr = rom_addr_t'(col) + line_base;

	assign last_rep_h  = (h_rep == '1);
	assign last_col    = (col == LAST_COL);
	// Last fetch of one screen line
	assign end_of_line = last_rep_h && last_col;

	// Wait for room, then one fetch cycle
	always_comb begin
		case (state)
			READ:    next_state = fifo.room ? FILL : READ;
			default: next_state = READ;
		endcase
	end

	//////////////////////////////////////////////////
	// Counters, all stepped by a fetch
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= READ;
			h_rep     <= '0;
			v_rep     <= '0;
			col       <= '0;
			line_base <= '0;
		end else begin
			state <= next_state;
			if (fetch) begin
				h_rep <= h_rep + 1'b1;
				// Next stored pixel after eight copies
				if (last_rep_h)
					col <= last_col ? '0 : col + 1'b1;
				if (end_of_line) begin
					v_rep <= v_rep + 1'b1;
					// Same stored line eight times, then step down
					if (v_rep == '1)
						line_base <= (line_base == LAST_BASE) ? '0 :
							line_base + rom_addr_t'(IMG_W);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Address stays inside the image across the line wrap
	a_addr_range: assert property (@(posedge clk) disable iff (rst)
		fetch |-> (rom_addr < rom_addr_t'(IMG_WORDS)));

	// One word in flight at most, which keeps the room check safe
	a_fetch_spacing: assert property (@(posedge clk) disable iff (rst)
		fetch |=> !fetch);

endmodule

// File: hdl/tile_rom.sv
`timescale 1ns/1ps

module tile_rom import plane_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         fetch,
	input  rom_addr_t    rom_addr,
	pixel_fifo_if.writer fifo
);

	// Image storage
	pixel_t mem [IMG_WORDS];

	// Contents fixed at start-up from the package pattern
	initial begin
		for (int i = 0; i < IMG_WORDS; i++) begin
			mem[i] = image_pattern(rom_addr_t'(i));
		end
	end

	//////////////////////////////////////////////////
	// Registered read
	//////////////////////////////////////////////////

	// Data lands one cycle after the fetch
	always_ff @(posedge clk) begin
		fifo.wr_data <= mem[rom_addr];
	end

	// Valid strobe follows the fetch by one cycle
	always_ff @(posedge clk) begin
		if (rst)
			fifo.wr_en <= 1'b0;
		else
			fifo.wr_en <= fetch;
	end

	// Writer never lands on a full FIFO, given the room margin
	a_no_full_write: assert property (@(posedge clk) disable iff (rst)
		fetch |=> !fifo.full);

endmodule

// File: hdl/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo import plane_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic       clk,
	input  logic       rst,
	pixel_fifo_if.fifo fifo,
	input  logic       pop,
	output pixel_t     dout
);

	localparam int AW = $clog2(FIFO_DEPTH);

	// Storage and pointers
	pixel_t        mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	// Occupancy, one bit wider to hold FIFO_DEPTH
	logic [AW:0]   level;

	logic          do_wr;
	logic          do_rd;

	assign do_wr = fifo.wr_en;
	assign do_rd = pop;

	//////////////////////////////////////////////////
	// Status flags from the level
	//////////////////////////////////////////////////

	// Two slots kept free for the word still in the ROM
	assign fifo.room  = (level <= (AW+1)'(FIFO_DEPTH - 2));
	assign fifo.full  = (level == (AW+1)'(FIFO_DEPTH));
	assign fifo.empty = (level == '0);

	// Head of queue visible without a read cycle
	assign dout = mem[rd_ptr];

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= fifo.wr_data;
	end

	// Pointers wrap by their width
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		fifo.wr_en |-> !fifo.full);

	// Scan side found nothing to show
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		pop |-> !fifo.empty);

endmodule

// File: hdl/scan_timing.sv
`timescale 1ns/1ps

module scan_timing import plane_pkg::*; (
	input  logic clk,
	input  logic rst,
	output logic pix_stb,
	output logic active,
	output logic hsync_n,
	output logic vsync_n
);

	// Sync windows in raster coordinates
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int HS_END   = HS_START + H_SYNC;
	localparam int VS_START = V_ACTIVE + V_FRONT;
	localparam int VS_END   = VS_START + V_SYNC;

	// Ten-bit raster position
	logic [9:0] h_pos;
	logic [9:0] v_pos;

	logic       line_end;
	logic       frame_end;

	//////////////////////////////////////////////////
	// Pixel strobe at half the clk rate
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst)
			pix_stb <= 1'b0;
		else
			pix_stb <= ~pix_stb;
	end

	//////////////////////////////////////////////////
	// Counters
	//////////////////////////////////////////////////

	assign line_end  = (h_pos == 10'(H_TOTAL - 1));
	assign frame_end = (v_pos == 10'(V_TOTAL - 1));

	// Start in vertical blanking so the FIFO fills before line 0
	always_ff @(posedge clk) begin
		if (rst) begin
			h_pos <= '0;
			v_pos <= 10'(V_ACTIVE);
		end else if (pix_stb) begin
			if (line_end) begin
				h_pos <= '0;
				v_pos <= frame_end ? '0 : v_pos + 1'b1;
			end else begin
				h_pos <= h_pos + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	assign active = (h_pos < 10'(H_ACTIVE)) && (v_pos < 10'(V_ACTIVE));

	// Both syncs active low
	assign hsync_n = !((h_pos >= 10'(HS_START)) && (h_pos < 10'(HS_END)));
	assign vsync_n = !((v_pos >= 10'(VS_START)) && (v_pos < 10'(VS_END)));

endmodule

// File: hdl/pixel_out.sv
`timescale 1ns/1ps

module pixel_out import plane_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   pix_stb,
	input  logic   active,
	input  logic   hsync_n,
	input  logic   vsync_n,
	output logic   pop,
	input  pixel_t dout,
	output pixel_t rgb,
	output logic   de,
	output logic   hsync,
	output logic   vsync
);

	//////////////////////////////////////////////////
	// FIFO read
	//////////////////////////////////////////////////

	// One word per visible pixel, taken on the second clk of the pixel
	assign pop = pix_stb && active;

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	// Sampled every clk, so each pixel shows for two clks
	// Head word stays put until the pop so both samples match
	always_ff @(posedge clk) begin
		if (rst) begin
			rgb   <= '0;
			de    <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			// Black during blanking
			rgb   <= active ? dout : '0;
			de    <= active;
			hsync <= hsync_n;
			vsync <= vsync_n;
		end
	end

endmodule

// File: hdl/plane_top.sv
`timescale 1ns/1ps

module plane_top import plane_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic       clk,
	input  logic       rst,
	output logic [7:0] rgb,
	output logic       de,
	output logic       hsync,
	output logic       vsync
);

	// Fetch path
	logic      fetch;
	rom_addr_t rom_addr;

	// Scan path
	logic      pix_stb;
	logic      active;
	logic      hsync_n;
	logic      vsync_n;
	logic      pop;
	pixel_t    dout;

	pixel_fifo_if fifo_bus ();

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	display_plane display_plane_inst (
		.clk      (clk),
		.rst      (rst),
		.fifo     (fifo_bus.writer),
		.fetch    (fetch),
		.rom_addr (rom_addr)
	);

	tile_rom tile_rom_inst (
		.clk      (clk),
		.rst      (rst),
		.fetch    (fetch),
		.rom_addr (rom_addr),
		.fifo     (fifo_bus.writer)
	);

	//////////////////////////////////////////////////
	// Buffer between fetch and scan
	//////////////////////////////////////////////////

	pixel_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) pixel_fifo_inst (
		.clk  (clk),
		.rst  (rst),
		.fifo (fifo_bus.fifo),
		.pop  (pop),
		.dout (dout)
	);

	//////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////

	scan_timing scan_timing_inst (
		.clk     (clk),
		.rst     (rst),
		.pix_stb (pix_stb),
		.active  (active),
		.hsync_n (hsync_n),
		.vsync_n (vsync_n)
	);

	pixel_out pixel_out_inst (
		.clk     (clk),
		.rst     (rst),
		.pix_stb (pix_stb),
		.active  (active),
		.hsync_n (hsync_n),
		.vsync_n (vsync_n),
		.pop     (pop),
		.dout    (dout),
		.rgb     (rgb),
		.de      (de),
		.hsync   (hsync),
		.vsync   (vsync)
	);

endmodule

// File: verification/plane_tb.sv
`timescale 1ns/1ps

module plane_tb import plane_pkg::*; ();

	localparam int CLK_HALF       = 10;
	localparam int LINE_CLKS      = 2 * H_TOTAL;
	localparam int FRAME_CLKS     = LINE_CLKS * V_TOTAL;
	// Two full frames plus the blanking lead-in from line 480
	localparam int TIMEOUT_CYCLES = 2 * FRAME_CLKS + 120000;
	localparam int MAX_POINTS     = 16;

	// One screen position to sample
	typedef struct {
		int    frame;
		int    line;
		int    col;
		string name;
	} point_t;

	logic       clk;
	logic       rst;
	logic [7:0] rgb;
	logic       de;
	logic       hsync;
	logic       vsync;

	// Sample table, filled in time order
	point_t points [MAX_POINTS];
	int     point_err [MAX_POINTS] = '{default: 0};
	int     num_points = 0;
	int     hit_count = 0;

	// Screen position rebuilt from the outputs
	logic   tracking = 1'b0;
	logic   prev_de = 1'b0;
	logic   prev_hsync = 1'b1;
	logic   prev_vsync = 1'b1;
	int     frame = -1;
	int     line = -1;
	int     run_len = 0;
	int     col = 0;
	int     hs_len = 0;
	int     vs_len = 0;
	pixel_t expected;

	// Tallies, errors and checks per test
	int err_reset = 0;
	int err_pre = 0;
	int err_vs = 0;
	int n_vs = 0;
	int err_hs = 0;
	int n_hs = 0;
	int err_de = 0;
	int n_de = 0;
	int err_runs = 0;
	int n_runs = 0;
	int err_blank = 0;
	int n_blank = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycles = 0;

	plane_top #(
		.FIFO_DEPTH (16)
	) plane_top_inst (
		.clk   (clk),
		.rst   (rst),
		.rgb   (rgb),
		.de    (de),
		.hsync (hsync),
		.vsync (vsync)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic add_point(input int f, input int l, input int c, input string name);
		points[num_points] = '{f, l, c, name};
		num_points++;
	endtask

	task automatic report_test(input string name, input int nerr, input int nchk);
		if (nchk == 0) begin
			$display("Test %s: FAIL, nothing was measured", name);
			tests_failed++;
			errors++;
		end else if (nerr != 0) begin
			$display("Test %s: FAIL, %0d of %0d checks wrong", name, nerr, nchk);
			tests_failed++;
			errors += nerr;
		end else begin
			$display("Test %s: PASS, %0d checks", name, nchk);
			tests_passed++;
		end
	endtask

	// Run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: table point %0d not reached in %0d cycles", hit_count, cycles);
			$display("Errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Output monitor, sampled mid-cycle
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (tracking) begin
			// Frame boundary at the vsync fall
			if (prev_vsync && !vsync) begin
				if (frame >= 0) begin
					n_runs++;
					if (line + 1 != V_ACTIVE) begin
						$display("Fail at time %0t: de runs expected %0d got %0d",
							$time, V_ACTIVE, line + 1);
						err_runs++;
					end
				end
				frame = frame + 1;
				line = -1;
				vs_len = 0;
			end
			if (!vsync)
				vs_len++;
			if (!prev_vsync && vsync) begin
				n_vs++;
				if (vs_len != V_SYNC * LINE_CLKS) begin
					$display("Fail at time %0t: vsync low clks expected %0d got %0d",
						$time, V_SYNC * LINE_CLKS, vs_len);
					err_vs++;
				end
			end
			// Horizontal sync width
			if (prev_hsync && !hsync)
				hs_len = 0;
			if (!hsync)
				hs_len++;
			if (!prev_hsync && hsync) begin
				n_hs++;
				if (hs_len != 2 * H_SYNC) begin
					$display("Fail at time %0t: hsync low clks expected %0d got %0d",
						$time, 2 * H_SYNC, hs_len);
					err_hs++;
				end
			end
			// Line start at the de rise
			if (!prev_de && de) begin
				line++;
				run_len = 0;
				if (frame < 0) begin
					$display("Fail: de went high before the first vsync pulse");
					err_pre++;
				end
			end
			if (de)
				run_len++;
			if (prev_de && !de) begin
				n_de++;
				if (run_len != 2 * H_ACTIVE) begin
					$display("Fail at time %0t: de high clks expected %0d got %0d",
						$time, 2 * H_ACTIVE, run_len);
					err_de++;
				end
			end
			// Black outside the visible window
			if (!de) begin
				n_blank++;
				if (rgb !== 8'h00) begin
					$display("Fail at time %0t: rgb expected 00 got %h", $time, rgb);
					err_blank++;
				end
			end
			// Two clks per pixel
			col = (run_len - 1) >> 1;
			if (hit_count < num_points && de && frame == points[hit_count].frame &&
				line == points[hit_count].line && col == points[hit_count].col) begin
				// Stored pixel under an 8x8 block
				expected = image_pattern(rom_addr_t'((line >> SCALE_SHIFT) * IMG_W +
					(col >> SCALE_SHIFT)));
				if (rgb !== expected) begin
					$display("Fail at time %0t: rgb expected %h got %h", $time, expected, rgb);
					point_err[hit_count]++;
				end
				hit_count++;
			end
			prev_de = de;
			prev_hsync = hsync;
			prev_vsync = vsync;
		end
	end

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		// Corners, block edges and mid-screen
		add_point(0, 0, 0, "top_left");
		add_point(0, 0, 7, "block_edge_left");
		add_point(0, 0, 8, "block_edge_right");
		add_point(0, 0, 639, "top_right");
		add_point(0, 7, 3, "block_last_row");
		add_point(0, 8, 3, "block_next_row");
		add_point(0, 240, 320, "mid_screen");
		add_point(0, 243, 325, "mid_block_same");
		add_point(0, 479, 0, "bottom_left");
		add_point(0, 479, 639, "bottom_right");
		// Second frame, shows the address wrap
		add_point(1, 0, 0, "wrap_top_left");
		add_point(1, 100, 200, "wrap_inner");
		add_point(1, 240, 320, "wrap_mid_screen");
		add_point(1, 479, 639, "wrap_bottom_right");

		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		// Reset levels
		if (hsync !== 1'b1) begin
			$display("Fail at time %0t: hsync expected 1 got %b", $time, hsync);
			err_reset++;
		end
		if (vsync !== 1'b1) begin
			$display("Fail at time %0t: vsync expected 1 got %b", $time, vsync);
			err_reset++;
		end
		if (de !== 1'b0) begin
			$display("Fail at time %0t: de expected 0 got %b", $time, de);
			err_reset++;
		end
		if (rgb !== 8'h00) begin
			$display("Fail at time %0t: rgb expected 00 got %h", $time, rgb);
			err_reset++;
		end
		@(posedge clk);
		tracking = 1'b1;

		while (frame < 0)
			@(posedge clk);
		report_test("reset_state", err_reset + err_pre, 5);

		for (int i = 0; i < num_points; i++) begin
			while (hit_count <= i)
				@(posedge clk);
			report_test(points[i].name, point_err[i], 1);
		end

		report_test("vsync_width", err_vs, n_vs);
		report_test("hsync_width", err_hs, n_hs);
		report_test("de_run_length", err_de, n_de);
		report_test("de_runs_per_frame", err_runs, n_runs);
		report_test("blank_black", err_blank, n_blank);
		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: plane_top.f
hdl/plane_pkg.sv
hdl/pixel_fifo_if.sv
hdl/display_plane.sv
hdl/tile_rom.sv
hdl/pixel_fifo.sv
hdl/scan_timing.sv
hdl/pixel_out.sv
hdl/plane_top.sv
verification/plane_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the plane_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module plane_tb \
	-f plane_top.f \
	-o plane_sim; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/plane_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "No errors"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
